/* hw/popeye_params.svh */
// Main-board bus parameters
// Widths and sizes shared by the bus logic
`ifndef POPEYE_PARAMS_SVH
`define POPEYE_PARAMS_SVH

// CPU bus
`define POPEYE_AW       16
`define POPEYE_DW       8

// Work RAM, 2 KiB
`define POPEYE_RAM_AW   11

// Program ROM window
`define POPEYE_ROM_AW   15

`endif

/* hw/popeye_bus_pkg.sv */
// Memory map types
// Region of a CPU memory cycle and the device selects
// that the decoder hands to the read mux
`default_nettype none

package popeye_bus_pkg;

    // Region codes follow ad[15:13]
    typedef enum logic [2:0] {
        region_rom = 3'b000,    // 0000-7fff
        region_ram = 3'b100,    // 8000-9fff
        region_txt = 3'b101,    // a000-bfff
        region_bg  = 3'b110,    // c000-dfff
        region_sec = 3'b111     // e000-ffff
    } region_e;

    // One select per device that can answer a read
    typedef struct packed {
        logic rom_cs;
        logic ram_cs;
        logic in_cs;
        logic sec_cs;
    } dev_sel_s;

endpackage

`default_nettype wire

/* hw/popeye_io_pkg.sv */
// Cabinet I/O types
// Sound chip port-A latch and the input port numbers
`default_nettype none

`include "popeye_params.svh"

package popeye_io_pkg;

    // Port-A fields as used by the board
    typedef struct packed {
        logic [3:0] spare;
        logic [2:0] dip_row;    // Selects one dip_sw2 bit
        logic       flip;       // Screen flip
    } port_a_f;

    // Written as a byte, read by field
    typedef union packed {
        logic [`POPEYE_DW-1:0] raw;
        port_a_f               f;
    } port_a_u;

    // I/O read port from ad[1:0]
    typedef enum logic [1:0] {
        port_dips   = 2'd0,
        port_system = 2'd1,
        port_p2     = 2'd2,
        port_p1     = 2'd3
    } in_port_e;

endpackage

`default_nettype wire

/* hw/popeye_bus_decode.sv */
// Main bus decoder
// Undoes the board's address scramble, decodes the memory
// map and the I/O space, and registers the strobes sent to
// the video and DMA logic
`timescale 1ns/1ns
`default_nettype none

`include "popeye_params.svh"

module popeye_bus_decode (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cpu_cen,
    input  logic [`POPEYE_AW-1:0]        a,
    input  logic                         rd_n,
    input  logic                         wr_n,
    input  logic                         mreq_n,
    input  logic                         iorq_n,
    input  logic                         dmcs,
    output logic [`POPEYE_AW-1:0]        ad,
    output logic [`POPEYE_ROM_AW-1:0]    rom_addr,
    output popeye_bus_pkg::dev_sel_s     sel,
    output logic                         ram_we,
    output logic                         sec_wr,
    output logic                         io_rd,
    output logic                         io_wr,
    output logic                         memwr,
    output logic                         csv_l,
    output logic                         dwrbk,
    output logic                         csbw_n
);

    popeye_bus_pkg::region_e region;
    logic txt_cs;
    logic bg_cs;
    logic bg_l;     // bg select at last cen edge

    //////////////////////////////
    // Address descramble
    assign ad[2:0]   = ~a[2:0];
    assign ad[3]     = ~a[4];
    assign ad[4]     = ~a[5];
    assign ad[5]     = ~a[9];
    assign ad[6]     = a[3];
    assign ad[7]     = a[6];
    assign ad[8]     = a[7];
    assign ad[9]     = a[8];
    assign ad[15:10] = a[15:10];    // Top bits pass straight

    assign rom_addr = ad[`POPEYE_ROM_AW-1:0];

    //////////////////////////////
    // Map decode
    always_comb begin
        case (ad[15:13])
            3'b100:  region = popeye_bus_pkg::region_ram;
            3'b101:  region = popeye_bus_pkg::region_txt;
            3'b110:  region = popeye_bus_pkg::region_bg;
            3'b111:  region = popeye_bus_pkg::region_sec;
            default: region = popeye_bus_pkg::region_rom;
        endcase
    end

    always_comb begin
        sel    = '0;
        txt_cs = 1'b0;
        bg_cs  = 1'b0;
        if (iorq_n) begin
            case (region)
                popeye_bus_pkg::region_ram: sel.ram_cs = (!mreq_n || dmcs) && !ad[11];
                popeye_bus_pkg::region_txt: txt_cs = !mreq_n;
                popeye_bus_pkg::region_bg:  bg_cs  = !mreq_n;
                popeye_bus_pkg::region_sec: sel.sec_cs = 1'b1;
                default:                    sel.rom_cs = 1'b1;
            endcase
        end else begin
            sel.in_cs = 1'b1;   // Any I/O cycle
        end
    end

    assign ram_we = sel.ram_cs && !wr_n;
    assign sec_wr = sel.sec_cs && !wr_n;
    assign io_rd  = sel.in_cs && !rd_n;
    assign io_wr  = sel.in_cs && !wr_n;

    //////////////////////////////
    // Video and DMA strobes

    // Registered on every clock, not only on cen
    always_ff @(posedge clk) begin
        if (reset) begin
            memwr  <= 1'b0;
            csv_l  <= 1'b0;
            dwrbk  <= 1'b0;
            csbw_n <= 1'b1;
        end else begin
            memwr  <= !wr_n && !mreq_n;
            csv_l  <= txt_cs;
            dwrbk  <= bg_cs && !wr_n;
            csbw_n <= !(bg_cs || bg_l);   // Stretched over one cen period
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bg_l <= 1'b0;
        end else if (cpu_cen) begin
            bg_l <= bg_cs;
        end
    end

endmodule

`default_nettype wire

/* hw/popeye_work_ram.sv */
// Work RAM
// Single-port 2 KiB array clocked on the CPU enable,
// read data registered
`timescale 1ns/1ns
`default_nettype none

`include "popeye_params.svh"

module popeye_work_ram (
    input  logic                       clk,
    input  logic                       cen,
    input  logic [`POPEYE_RAM_AW-1:0]  addr,
    input  logic [`POPEYE_DW-1:0]      din,
    input  logic                       we,
    output logic [`POPEYE_DW-1:0]      q
);

    logic [`POPEYE_DW-1:0] mem [0:(1 << `POPEYE_RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                q <= mem[addr];     // Read only when not writing
            end
        end
    end

endmodule

`default_nettype wire

/* hw/popeye_security.sv */
// Protection chip
// Two data bytes pushed by the CPU form a 16-bit word,
// read back through an 8-bit window set by a shift count
`timescale 1ns/1ns
`default_nettype none

`include "popeye_params.svh"

module popeye_security (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cen,
    input  logic                   a0,
    input  logic [`POPEYE_DW-1:0]  din,
    input  logic                   wr,
    output logic [`POPEYE_DW-1:0]  dout
);

    logic [`POPEYE_DW-1:0]   cur;
    logic [`POPEYE_DW-1:0]   prev;
    logic [2:0]              shift;
    logic [2*`POPEYE_DW-1:0] word_sh;

    // Count register
    always_ff @(posedge clk) begin
        if (reset) begin
            shift <= 3'd0;
        end else if (cen && wr && a0) begin
            shift <= din[2:0];
        end
    end

    // Data push, current byte moves down
    always_ff @(posedge clk) begin
        if (cen && wr && !a0) begin
            prev <= cur;
            cur  <= din;
        end
    end

    // Window top at bit 15 - shift
    assign word_sh = {cur, prev} << shift;
    assign dout    = word_sh[2*`POPEYE_DW-1 -: `POPEYE_DW];

endmodule

`default_nettype wire

/* hw/popeye_cabinet_io.sv */
// Cabinet inputs
// Multiplexes joysticks, buttons and DIP switches onto the
// I/O read space and holds the sound chip's port-A latch,
// which carries the screen flip and the DIP row select
`timescale 1ns/1ns
`default_nettype none

`include "popeye_params.svh"

module popeye_cabinet_io (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cen,
    input  logic [1:0]             port_sel,
    input  logic                   io_rd,
    input  logic                   io_wr,
    input  logic                   a0,
    input  logic [`POPEYE_DW-1:0]  din,
    input  logic [4:0]             joystick1,
    input  logic [4:0]             joystick2,
    input  logic [1:0]             start_button,
    input  logic                   coin_input,
    input  logic                   service,
    input  logic                   initeo,
    input  logic [3:0]             dip_sw1,
    input  logic [7:0]             dip_sw2,
    output logic [`POPEYE_DW-1:0]  dout,
    output logic                   rv_n
);

    popeye_io_pkg::port_a_u  port_a;
    popeye_io_pkg::in_port_e port;
    logic [4:0]              joy;

    //////////////////////////////
    // Port-A latch
    always_ff @(posedge clk) begin
        if (reset) begin
            port_a.raw <= '0;
        end else if (cen && io_wr && a0) begin
            port_a.raw <= din;
        end
    end

    assign rv_n = !port_a.f.flip;

    //////////////////////////////
    // Input read
    assign port = popeye_io_pkg::in_port_e'(port_sel);
    assign joy  = (port == popeye_io_pkg::port_p1) ? joystick1 : joystick2;

    always_comb begin
        dout = '1;  // Idle bus reads high
        if (io_rd) begin
            case (port)
                popeye_io_pkg::port_dips: begin
                    dout[7]   = dip_sw2[port_a.f.dip_row];
                    dout[6:4] = 3'b000;
                    dout[3:0] = dip_sw1;
                end
                popeye_io_pkg::port_system: begin
                    dout[7]   = coin_input;
                    dout[6]   = service;
                    dout[5]   = initeo;     // Field parity from video
                    dout[3:2] = start_button;
                end
                default: begin
                    // Up and down swap places on the connector
                    dout[4] = joy[4];   // Punch
                    dout[3] = joy[2];
                    dout[2] = joy[3];
                    dout[1] = joy[1];
                    dout[0] = joy[0];
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/popeye_read_mux.sv */
// CPU read data mux
// Passes the byte of the one selected device, with the ROM
// byte bit order restored
`timescale 1ns/1ns
`default_nettype none

`include "popeye_params.svh"

module popeye_read_mux (
    input  popeye_bus_pkg::dev_sel_s  sel,
    input  logic [`POPEYE_DW-1:0]     rom_data,
    input  logic [`POPEYE_DW-1:0]     ram_q,
    input  logic [`POPEYE_DW-1:0]     in_data,
    input  logic [`POPEYE_DW-1:0]     sec_data,
    output logic [`POPEYE_DW-1:0]     cpu_din
);

    logic [3:0]            sel_bits;
    logic [`POPEYE_DW-1:0] rom_good;

    // ROM data lines are crossed in pairs on the board
    assign rom_good = {rom_data[3], rom_data[4], rom_data[2], rom_data[5],
                       rom_data[1], rom_data[6], rom_data[0], rom_data[7]};

    assign sel_bits = sel;  // rom, ram, in, sec

    always_comb begin
        case (sel_bits)
            4'b1000: cpu_din = rom_good;
            4'b0100: cpu_din = ram_q;
            4'b0010: cpu_din = in_data;
            4'b0001: cpu_din = sec_data;
            default: cpu_din = '0;   // None or clash
        endcase
    end

endmodule

`default_nettype wire

/* hw/popeye_main_bus.sv */
// Main-board bus logic
// Address descramble, map decode, work RAM, protection chip
// and cabinet I/O around an external Z80-class CPU bus
`timescale 1ns/1ns
`default_nettype none

`include "popeye_params.svh"

module popeye_main_bus (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cpu_cen,
    // CPU bus
    input  logic [`POPEYE_AW-1:0]        a,
    input  logic [`POPEYE_DW-1:0]        cpu_dout,
    input  logic                         rd_n,
    input  logic                         wr_n,
    input  logic                         mreq_n,
    input  logic                         iorq_n,
    output logic [`POPEYE_DW-1:0]        cpu_din,
    // DMA and video
    input  logic                         dmcs,
    input  logic                         initeo,
    output logic [`POPEYE_AW-1:0]        ad,
    output logic                         memwr,
    output logic                         csv_l,
    output logic                         dwrbk,
    output logic                         csbw_n,
    output logic                         rv_n,
    // Cabinet
    input  logic [4:0]                   joystick1,
    input  logic [4:0]                   joystick2,
    input  logic [1:0]                   start_button,
    input  logic                         coin_input,
    input  logic                         service,
    input  logic [3:0]                   dip_sw1,
    input  logic [7:0]                   dip_sw2,
    // ROM
    output logic [`POPEYE_ROM_AW-1:0]    rom_addr,
    output logic                         rom_cs,
    input  logic [`POPEYE_DW-1:0]        rom_data
);

    popeye_bus_pkg::dev_sel_s sel;
    logic                     ram_we;
    logic                     sec_wr;
    logic                     io_rd;
    logic                     io_wr;
    logic [`POPEYE_DW-1:0]    ram_q;
    logic [`POPEYE_DW-1:0]    in_data;
    logic [`POPEYE_DW-1:0]    sec_data;

    assign rom_cs = sel.rom_cs;

    popeye_bus_decode u_decode (
        .clk(clk), .reset(reset), .cpu_cen(cpu_cen), .a(a),
        .rd_n(rd_n), .wr_n(wr_n), .mreq_n(mreq_n), .iorq_n(iorq_n), .dmcs(dmcs),
        .ad(ad), .rom_addr(rom_addr), .sel(sel), .ram_we(ram_we), .sec_wr(sec_wr),
        .io_rd(io_rd), .io_wr(io_wr), .memwr(memwr), .csv_l(csv_l),
        .dwrbk(dwrbk), .csbw_n(csbw_n)
    );

    popeye_work_ram u_ram (
        .clk(clk), .cen(cpu_cen), .addr(ad[`POPEYE_RAM_AW-1:0]),
        .din(cpu_dout), .we(ram_we), .q(ram_q)
    );

    popeye_security u_security (
        .clk(clk), .reset(reset), .cen(cpu_cen), .a0(ad[0]),
        .din(cpu_dout), .wr(sec_wr), .dout(sec_data)
    );

    popeye_cabinet_io u_cabinet (
        .clk(clk), .reset(reset), .cen(cpu_cen), .port_sel(ad[1:0]),
        .io_rd(io_rd), .io_wr(io_wr), .a0(ad[0]), .din(cpu_dout),
        .joystick1(joystick1), .joystick2(joystick2), .start_button(start_button),
        .coin_input(coin_input), .service(service), .initeo(initeo),
        .dip_sw1(dip_sw1), .dip_sw2(dip_sw2), .dout(in_data), .rv_n(rv_n)
    );

    popeye_read_mux u_read_mux (
        .sel(sel), .rom_data(rom_data), .ram_q(ram_q),
        .in_data(in_data), .sec_data(sec_data), .cpu_din(cpu_din)
    );

endmodule

`default_nettype wire

/* bench/popeye_main_bus_asserts.sv */
// Bus decoder assertions
// Bound into the decoder, checks select exclusivity
// and the registered strobes
`timescale 1ns/1ns
`default_nettype none

module popeye_main_bus_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     wr_n,
    input logic                     mreq_n,
    input logic                     memwr,
    input logic                     csv_l,
    input logic                     dwrbk,
    input logic                     csbw_n,
    input popeye_bus_pkg::dev_sel_s sel
);

    int unsigned fail_count = 0;    // Assertion failures so far

    sel_onehot: assert property (@(posedge clk) $onehot0(sel))
        else begin
            $error("More than one device select is active");
            fail_count++;
        end

    // Memory write shows on memwr one clock later
    memwr_follow: assert property (@(posedge clk)
        !reset |=> memwr == $past(!wr_n && !mreq_n))
        else begin
            $error("memwr did not follow the memory write");
            fail_count++;
        end

    strobes_idle: assert property (@(posedge clk)
        reset |=> !memwr && !csv_l && !dwrbk && csbw_n)
        else begin
            $error("Strobes left their idle values during reset");
            fail_count++;
        end

endmodule

`default_nettype wire

/* bench/popeye_main_bus_tb.sv */
// Main-board bus testbench
// Plays the CPU with random bus cycles and checks the DUT
// against a model of RAM, protection chip and port-A latch
`timescale 1ns/1ns
`default_nettype none

`include "popeye_params.svh"

module popeye_main_bus_tb;

    localparam int N          = 100;            // Iterations per test
    localparam int TOTAL_ACC  = 7 * N + 2;
    localparam int TIMEOUT    = TOTAL_ACC * 3 + 100;

    logic                      clk;
    logic                      reset;
    logic                      cpu_cen;
    logic [`POPEYE_AW-1:0]     a;
    logic [`POPEYE_DW-1:0]     cpu_dout;
    logic                      rd_n;
    logic                      wr_n;
    logic                      mreq_n;
    logic                      iorq_n;
    logic [`POPEYE_DW-1:0]     cpu_din;
    logic                      dmcs;
    logic                      initeo;
    logic [`POPEYE_AW-1:0]     ad;
    logic                      memwr;
    logic                      csv_l;
    logic                      dwrbk;
    logic                      csbw_n;
    logic                      rv_n;
    logic [4:0]                joystick1;
    logic [4:0]                joystick2;
    logic [1:0]                start_button;
    logic                      coin_input;
    logic                      service;
    logic [3:0]                dip_sw1;
    logic [7:0]                dip_sw2;
    logic [`POPEYE_ROM_AW-1:0] rom_addr;
    logic                      rom_cs;
    logic [`POPEYE_DW-1:0]     rom_data;

    // Reference model state
    logic [7:0]  ram_mem [0:2047];
    bit          ram_known [0:2047];
    logic [7:0]  sec_cur;
    logic [7:0]  sec_prev;
    logic [2:0]  sec_shift;
    logic [7:0]  port_a;
    logic        prev_bg;      // bg select at last cen edge
    logic [3:0]  last_strobes; // memwr, csv_l, dwrbk, csbw_n after the last access

    string       test_name;
    int          cycles;
    logic [15:0] addr;
    logic [1:0]  mode;

    popeye_main_bus popeye_main_bus_i (.*);

    bind popeye_bus_decode popeye_main_bus_asserts u_asserts (
        .clk(clk), .reset(reset), .wr_n(wr_n), .mreq_n(mreq_n), .memwr(memwr),
        .csv_l(csv_l), .dwrbk(dwrbk), .csbw_n(csbw_n), .sel(sel)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR timeout, the bus tests did not finish within %0d cycles", TIMEOUT);
        $display("Some tests failed");
        $fatal(1, "Timeout");
    end

    // Stop at the first failing bound assertion
    initial begin
        wait (popeye_main_bus_i.u_decode.u_asserts.fail_count != 0);
        $display("ERROR a bound assertion on the decoder failed during %s", test_name);
        $display("Some tests failed");
        $fatal(1, "Assertion failure");
    end

    //////////////////////////////
    // Model rules
    function automatic logic [15:0] descramble(input logic [15:0] x);
        return {x[15:10], x[8], x[7], x[6], x[3], ~x[9], ~x[5], ~x[4], ~x[2:0]};
    endfunction

    function automatic logic [7:0] unswap(input logic [7:0] d);
        int         src[8];
        logic [7:0] r;
        src = '{7, 0, 6, 1, 5, 2, 4, 3};   // ROM bit feeding output bit 0 upward
        for (int i = 0; i < 8; i++) begin
            r[i] = d[src[i]];
        end
        return r;
    endfunction

    function automatic logic [7:0] port_byte(input logic [1:0] p);
        logic [4:0] j;
        j = (p == 2'd3) ? joystick1 : joystick2;
        case (p)
            2'd0:    return {dip_sw2[port_a[3:1]], 3'b000, dip_sw1};
            2'd1:    return {coin_input, service, initeo, 1'b1, start_button, 2'b11};
            default: return {3'b111, j[4], j[2], j[3], j[1], j[0]};  // Up/down crossed
        endcase
    endfunction

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Some tests failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_idle();
        check_value("memwr", 16'd0, memwr);
        check_value("csv_l", 16'd0, csv_l);
        check_value("dwrbk", 16'd0, dwrbk);
        check_value("csbw_n", 16'd1, csbw_n);
        check_value("rv_n", 16'd1, rv_n);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset   = 1'b1;
        cpu_cen = 1'b0;
        repeat (4) @(negedge clk);
        @(posedge clk);
        #1;
        check_idle();
        @(negedge clk);
        reset        = 1'b0;
        port_a       = 8'h00;
        sec_shift    = 3'd0;
        prev_bg      = 1'b0;
        last_strobes = 4'b0001;
    endtask

    //////////////////////////////
    // One CPU access, two cycles, cen on the second
    task automatic run_access(input logic [15:0] addr_in, input logic wr, input logic mem,
                              input logic io, input logic dma, input logic [7:0] wdata);
        logic [15:0] xad;
        logic        rom_now;
        logic        ram_hit;
        logic        txt_now;
        logic        bg_now;
        logic        sec_now;
        logic        check_din;
        logic [15:0] word;
        logic [7:0]  exp_din;
        logic [3:0]  exp_strobes;   // memwr, csv_l, dwrbk, csbw_n

        @(negedge clk);
        cpu_cen  = 1'b0;
        a        = addr_in;
        cpu_dout = wdata;
        wr_n     = !wr;
        rd_n     = wr;
        mreq_n   = !mem;
        iorq_n   = !io;
        dmcs     = dma;
        rom_data = 8'($urandom);
        {joystick1, joystick2, start_button, coin_input, service, initeo} = 15'($urandom);
        {dip_sw1, dip_sw2} = 12'($urandom);

        xad     = descramble(addr_in);
        rom_now = !io && !xad[15];
        ram_hit = !io && xad[15:13] == 3'b100 && (mem || dma) && !xad[11];
        txt_now = !io && xad[15:13] == 3'b101 && mem;
        bg_now  = !io && xad[15:13] == 3'b110 && mem;
        sec_now = !io && xad[15:13] == 3'b111;
        word    = {sec_cur, sec_prev};

        exp_strobes = {wr && mem, txt_now, bg_now && wr, !(bg_now || prev_bg)};

        // Strobes keep the last access until the next clock edge
        #1;
        check_value("strobes_held", last_strobes, {memwr, csv_l, dwrbk, csbw_n});
        @(posedge clk);
        #1;
        check_value("strobes_registered", exp_strobes, {memwr, csv_l, dwrbk, csbw_n});

        @(negedge clk);
        cpu_cen = 1'b1;
        @(posedge clk);
        #1;

        check_din = !wr;
        if (io) begin
            exp_din = port_byte(xad[1:0]);
        end else if (rom_now) begin
            exp_din = unswap(rom_data);
        end else if (sec_now) begin
            exp_din = word[15 - sec_shift -: 8];
        end else if (ram_hit) begin
            exp_din   = ram_mem[xad[10:0]];
            check_din = !wr && ram_known[xad[10:0]];    // Skip never written cells
        end else begin
            exp_din = 8'h00;
        end

        check_value("ad", xad, ad);
        check_value("rom_addr", {1'b0, xad[14:0]}, {1'b0, rom_addr});
        check_value("rom_cs", rom_now, rom_cs);
        if (check_din) begin
            check_value("cpu_din", exp_din, cpu_din);
        end
        check_value("memwr", wr && mem, memwr);
        check_value("csv_l", txt_now, csv_l);
        check_value("dwrbk", bg_now && wr, dwrbk);
        check_value("csbw_n", !(bg_now || prev_bg), csbw_n);

        // State changes at this cen edge
        prev_bg      = bg_now;
        last_strobes = exp_strobes;
        if (wr && ram_hit) begin
            ram_mem[xad[10:0]]   = wdata;
            ram_known[xad[10:0]] = 1'b1;
        end
        if (wr && sec_now) begin
            if (xad[0]) begin
                sec_shift = wdata[2:0];
            end else begin
                sec_prev = sec_cur;
                sec_cur  = wdata;
            end
        end
        if (wr && io && xad[0]) begin
            port_a = wdata;
        end
        check_value("rv_n", !port_a[0], rv_n);
    endtask

    //////////////////////////////
    // Test sequence
    initial begin
        reset        = 1'b1;
        cpu_cen      = 1'b0;
        a            = '0;
        cpu_dout     = '0;
        rd_n         = 1'b1;
        wr_n         = 1'b1;
        mreq_n       = 1'b1;
        iorq_n       = 1'b1;
        dmcs         = 1'b0;
        initeo       = 1'b0;
        joystick1    = '0;
        joystick2    = '0;
        start_button = '0;
        coin_input   = 1'b0;
        service      = 1'b0;
        dip_sw1      = '0;
        dip_sw2      = '0;
        rom_data     = '0;
        void'($urandom(32'h03f5d20b));

        test_name = "reset";
        apply_reset();

        // Two pushes so both protection bytes are defined
        test_name = "security_setup";
        repeat (2) run_access(16'hffff, 1'b1, 1'b1, 1'b0, 1'b0, 8'($urandom));

        test_name = "rom_read";
        repeat (N) run_access(16'($urandom), 1'b0, 1'b1, 1'b0, 1'b0, 8'h00);

        test_name = "work_ram";
        repeat (N) begin
            addr = {3'b100, 1'($urandom), ($urandom_range(0, 3) == 0), 5'd0, 6'($urandom)};
            mode = 2'($urandom);    // mreq and dmcs combinations
            run_access(addr, 1'($urandom), mode[1], 1'b0, mode[0], 8'($urandom));
        end

        test_name = "security";
        repeat (N) begin
            run_access({3'b111, 13'($urandom)}, 1'b1, 1'b1, 1'b0, 1'b0, 8'($urandom));
            run_access({3'b111, 13'($urandom)}, 1'b0, 1'b1, 1'b0, 1'b0, 8'h00);
        end

        test_name = "cabinet_io";
        repeat (N) begin
            run_access(16'($urandom), 1'b1, 1'b0, 1'b1, 1'b0, 8'($urandom));
            run_access(16'($urandom), 1'b0, 1'b0, 1'b1, 1'b0, 8'h00);
        end

        test_name = "video_strobes";
        repeat (N) begin
            addr = {($urandom_range(0, 1) == 1) ? 3'b101 : 3'b110, 13'($urandom)};
            run_access(addr, 1'($urandom), ($urandom_range(0, 3) != 0), 1'b0, 1'b0,
                       8'($urandom));
        end

        // Reset with a video cycle still on the bus
        test_name = "reset_idle";
        apply_reset();

        if (popeye_main_bus_i.u_decode.u_asserts.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("ERROR %0d bound assertion failures",
                     popeye_main_bus_i.u_decode.u_asserts.fail_count);
            $display("Some tests failed");
            $fatal(1, "Bound assertion failure");
        end
    end

endmodule

`default_nettype wire

/* popeye_main_bus.f */
+incdir+hw
hw/popeye_bus_pkg.sv
hw/popeye_io_pkg.sv
hw/popeye_bus_decode.sv
hw/popeye_work_ram.sv
hw/popeye_security.sv
hw/popeye_cabinet_io.sv
hw/popeye_read_mux.sv
hw/popeye_main_bus.sv
bench/popeye_main_bus_asserts.sv
bench/popeye_main_bus_tb.sv
